// ==== Makefile ====
# Verilator simulation of the ALU core

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --top-module aluCoreTb -f sim.f -Mdir obj_dir
	./obj_dir/ValuCoreTb | tee $(LOG)
	@grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/alu.sv ====
`default_nettype none

module alu
	import archPkg::*;
	import isaPkg::*;
(
	input  dataT  a,
	input  dataT  b,
	input  aluOpE op,
	output dataT  result,
	output psrT   flags
);

	logic [dataWidth:0] sum;
	logic [dataWidth:0] diff;
	logic addOvf;
	logic subOvf;

	//////////////////////////////////////////////////////////////////////
	// Adder and subtractor
	//////////////////////////////////////////////////////////////////////

	// Extra top bit is the carry, or the borrow on subtract
	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	// Same signs in, other sign out
	assign addOvf = (a[dataWidth-1] == b[dataWidth-1]) &&
		(sum[dataWidth-1] != a[dataWidth-1]);

	// Different signs in, result sign differs from a
	assign subOvf = (a[dataWidth-1] != b[dataWidth-1]) &&
		(diff[dataWidth-1] != a[dataWidth-1]);

	//////////////////////////////////////////////////////////////////////
	// Result and candidate flags
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Compare flags always on offer, masking happens in execute
		flags = '0;
		flags[psrL] = a < b;
		flags[psrZ] = (diff[dataWidth-1:0] == '0);
		flags[psrN] = $signed(a) < $signed(b);

		// Borrow and overflow unless adding
		flags[psrC] = diff[dataWidth];
		flags[psrF] = subOvf;
		result = diff[dataWidth-1:0];

		case (op)
			opAdd: begin
				result = sum[dataWidth-1:0];
				flags[psrC] = sum[dataWidth];
				flags[psrF] = addOvf;
			end
			opSub: result = diff[dataWidth-1:0];
			opOr:  result = a | b;
			opAnd: result = a & b;
			opXor: result = a ^ b;
			opNot: result = ~a;
			// Low half of the product
			opMult: result = a * b;
			opCmp: result = diff[dataWidth-1:0];
		endcase
	end

endmodule

`default_nettype wire

// ==== design/aluCore.sv ====
`default_nettype none

module aluCore
	import archPkg::*;
	import isaPkg::*;
(
	input  logic   clk,
	input  logic   rst,
	// Instruction input
	input  logic   inValid,
	output logic   inReady,
	input  aluOpE  inOp,
	input  regIdxT inDest,
	input  regIdxT inSrcA,
	input  regIdxT inSrcB,
	input  logic   inUseImm,
	input  immT    inImm,
	// Result output
	output logic   resValid,
	input  logic   resReady,
	output dataT   resData,
	output regIdxT resDest,
	output logic   resWrote,
	output psrT    resPsr
);

	// Read side of the register file
	regIdxT rdAddrA;
	regIdxT rdAddrB;
	dataT rdDataA;
	dataT rdDataB;

	// Write side, owned by execute
	logic wen;
	regIdxT waddr;
	dataT wdata;

	// Fetch to execute
	stageIf stage ();

	regFile regFileInst (
		.clk     (clk),
		.rst     (rst),
		.rdAddrA (rdAddrA),
		.rdAddrB (rdAddrB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wen     (wen),
		.waddr   (waddr),
		.wdata   (wdata)
	);

	operandFetch fetchInst (
		.clk      (clk),
		.rst      (rst),
		.inValid  (inValid),
		.inReady  (inReady),
		.inOp     (inOp),
		.inDest   (inDest),
		.inSrcA   (inSrcA),
		.inSrcB   (inSrcB),
		.inUseImm (inUseImm),
		.inImm    (inImm),
		.rdAddrA  (rdAddrA),
		.rdAddrB  (rdAddrB),
		.rdDataA  (rdDataA),
		.rdDataB  (rdDataB),
		.stage    (stage)
	);

	executeStage executeInst (
		.clk      (clk),
		.rst      (rst),
		.stage    (stage),
		.wen      (wen),
		.waddr    (waddr),
		.wdata    (wdata),
		.resValid (resValid),
		.resReady (resReady),
		.resData  (resData),
		.resDest  (resDest),
		.resWrote (resWrote),
		.resPsr   (resPsr)
	);

endmodule

`default_nettype wire

// ==== design/archPkg.sv ====
`default_nettype none

package archPkg;

	//////////////////////////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////////////////////////

	// Machine word
	localparam int dataWidth = 16;

	// Sixteen registers, number 0 hard-wired to zero
	localparam int regCount = 16;

	typedef logic [dataWidth-1:0] dataT;
	typedef logic [3:0] regIdxT;

	//////////////////////////////////////////////////////////////////////
	// Processor status register
	//////////////////////////////////////////////////////////////////////

	// Flag word {C, L, F, Z, N}
	typedef logic [4:0] psrT;

	// Bit positions, C on top
	localparam int psrC = 4;
	localparam int psrL = 3;
	localparam int psrF = 2;
	localparam int psrZ = 1;
	localparam int psrN = 0;

endpackage

`default_nettype wire

// ==== design/executeStage.sv ====
`default_nettype none

module executeStage
	import archPkg::*;
	import isaPkg::*;
(
	input  logic   clk,
	input  logic   rst,
	// From operand fetch
	stageIf.accept stage,
	// Register file write
	output logic   wen,
	output regIdxT waddr,
	output dataT   wdata,
	// Result output
	output logic   resValid,
	input  logic   resReady,
	output dataT   resData,
	output regIdxT resDest,
	output logic   resWrote,
	output psrT    resPsr
);

	dataT aluResult;
	psrT aluFlags;
	psrT flagMask;
	psrT psr;
	logic fire;

	alu aluInst (
		.a      (stage.a),
		.b      (stage.b),
		.op     (stage.op),
		.result (aluResult),
		.flags  (aluFlags)
	);

	// Room when empty or when the result leaves now
	assign stage.ready = !resValid || resReady;
	assign fire = stage.valid && stage.ready;

	//////////////////////////////////////////////////////////////////////
	// Commit
	//////////////////////////////////////////////////////////////////////

	// Which flags this opcode owns
	always_comb begin
		case (stage.op)
			opAdd, opSub: flagMask = flagMaskAdd;
			opCmp:        flagMask = flagMaskCmp;
			default:      flagMask = '0;
		endcase
	end

	// Write lands at the same edge as the result register
	assign wen = fire && stage.writesReg;
	assign waddr = stage.dest;
	assign wdata = aluResult;

	// Status register, untouched bits keep their value
	always_ff @(posedge clk) begin
		if (rst) begin
			psr <= '0;
		end else if (fire) begin
			psr <= (psr & ~flagMask) | (aluFlags & flagMask);
		end
	end

	// Output valid
	always_ff @(posedge clk) begin
		if (rst) begin
			resValid <= 1'b0;
		end else if (stage.ready) begin
			resValid <= stage.valid;
		end
	end

	// Result payload
	always_ff @(posedge clk) begin
		if (fire) begin
			resData <= aluResult;
			resDest <= stage.dest;
			resWrote <= stage.writesReg;
		end
	end

	assign resPsr = psr;

endmodule

`default_nettype wire

// ==== design/isaPkg.sv ====
`default_nettype none

package isaPkg;

	import archPkg::*;

	//////////////////////////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////////////////////////

	localparam int opCount = 8;

	// Three-bit ALU opcode
	typedef enum logic [2:0] {
		opAdd  = 3'd0,
		opSub  = 3'd1,
		opOr   = 3'd2,
		opAnd  = 3'd3,
		opXor  = 3'd4,
		opNot  = 3'd5,
		opMult = 3'd6,
		opCmp  = 3'd7
	} aluOpE;

	// Immediate, same width as a data word
	typedef logic [dataWidth-1:0] immT;

	//////////////////////////////////////////////////////////////////////
	// Side effects per opcode
	//////////////////////////////////////////////////////////////////////

	// One bit per opcode, CMP is the only one without a register write
	localparam logic [opCount-1:0] writesRegMask = 8'b0111_1111;

	// ADD and SUB keep C and F
	localparam psrT flagMaskAdd = psrT'(1 << psrC) | psrT'(1 << psrF);

	// CMP keeps L, Z and N
	localparam psrT flagMaskCmp = psrT'(1 << psrL) | psrT'(1 << psrZ) | psrT'(1 << psrN);

endpackage

`default_nettype wire

// ==== design/operandFetch.sv ====
`default_nettype none

module operandFetch
	import archPkg::*;
	import isaPkg::*;
(
	input  logic   clk,
	input  logic   rst,
	// Instruction input
	input  logic   inValid,
	output logic   inReady,
	input  aluOpE  inOp,
	input  regIdxT inDest,
	input  regIdxT inSrcA,
	input  regIdxT inSrcB,
	input  logic   inUseImm,
	input  immT    inImm,
	// Register file reads
	output regIdxT rdAddrA,
	output regIdxT rdAddrB,
	input  dataT   rdDataA,
	input  dataT   rdDataB,
	// Toward execute
	stageIf.issue  stage
);

	logic hazard;
	logic slotFree;
	logic accept;
	dataT operandB;

	// Sources go straight to the register file
	assign rdAddrA = inSrcA;
	assign rdAddrB = inSrcB;

	// Immediate replaces source B
	assign operandB = inUseImm ? dataT'(inImm) : rdDataB;

	//////////////////////////////////////////////////////////////////////
	// Interlock
	//////////////////////////////////////////////////////////////////////

	// Held op still has to write a register that the new op reads
	// (B only counts when it is really read)
	assign hazard = stage.valid && stage.writesReg && stage.dest != '0 &&
		(stage.dest == inSrcA || (!inUseImm && stage.dest == inSrcB));

	// Empty, or emptied at this edge
	assign slotFree = !stage.valid || stage.ready;

	// Even when the slot drains, the register file is stale until the edge
	assign inReady = slotFree && !hazard;
	assign accept = inValid && inReady;

	//////////////////////////////////////////////////////////////////////
	// Operation register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			stage.valid <= 1'b0;
		end else if (accept) begin
			stage.valid <= 1'b1;
		end else if (stage.ready) begin
			stage.valid <= 1'b0;
		end
	end

	// Payload
	always_ff @(posedge clk) begin
		if (accept) begin
			stage.op <= inOp;
			stage.dest <= inDest;
			stage.a <= rdDataA;
			stage.b <= operandB;
			stage.writesReg <= writesRegMask[inOp];
		end
	end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`default_nettype none

module regFile
	import archPkg::*;
(
	input  logic   clk,
	input  logic   rst,
	// Read ports
	input  regIdxT rdAddrA,
	input  regIdxT rdAddrB,
	output dataT   rdDataA,
	output dataT   rdDataB,
	// Write port
	input  logic   wen,
	input  regIdxT waddr,
	input  dataT   wdata
);

	// Storage for registers 1 to 15 only
	dataT regs [1:regCount-1];

	//////////////////////////////////////////////////////////////////////
	// Write
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			// All registers start at zero
			for (int i = 1; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			// Writes to register 0 fall on the floor
			regs[waddr] <= wdata;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read
	//////////////////////////////////////////////////////////////////////

	// Register 0 reads as zero
	assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// ==== design/stageIf.sv ====
`default_nettype none

// One issued operation, fetch to execute
interface stageIf
	import archPkg::*, isaPkg::*;
();

	// Handshake
	logic valid;
	logic ready;

	// Operation with operands already resolved
	aluOpE op;
	regIdxT dest;
	dataT a;
	dataT b;
	logic writesReg;

	// Operand fetch side
	modport issue (output valid, op, dest, a, b, writesReg, input ready);

	// Execute side
	modport accept (input valid, op, dest, a, b, writesReg, output ready);

endinterface

`default_nettype wire

// ==== sim.f ====
design/archPkg.sv
design/isaPkg.sv
design/stageIf.sv
design/regFile.sv
design/operandFetch.sv
design/alu.sv
design/executeStage.sv
design/aluCore.sv
verif/aluCoreChecker.sv
verif/aluCore_assert.sv
verif/aluCoreTb.sv

// ==== verif/aluCoreChecker.sv ====
`default_nettype none

module aluCoreChecker
	import archPkg::*, isaPkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   inValid,
	input  logic   inReady,
	input  aluOpE  inOp,
	input  regIdxT inDest,
	input  regIdxT inSrcA,
	input  regIdxT inSrcB,
	input  logic   inUseImm,
	input  immT    inImm,
	input  logic   resValid,
	input  logic   resReady,
	input  dataT   resData,
	input  regIdxT resDest,
	input  logic   resWrote,
	input  psrT    resPsr,
	output int     errorCount,
	output int     resultCount,
	output int     pendingCount
);

	localparam int perTest = 200;

	// One expected output transfer
	typedef struct packed {
		dataT data;
		regIdxT dest;
		logic wrote;
		psrT psr;
	} expectT;

	string testNames [5] = '{"immediate loads", "add and sub", "compare",
		"logic and multiply", "full random"};

	dataT modelRegs [16];
	psrT modelPsr;
	expectT expected [$];
	int testErrors;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic expectT applyInstr(input aluOpE op, input regIdxT dest,
		input regIdxT srcA, input regIdxT srcB, input logic useImm, input immT imm);
		dataT a;
		dataT b;
		logic [31:0] wide;
		int sa;
		int sb;
		int sres;
		expectT e;
		a = (srcA == '0) ? '0 : modelRegs[srcA];
		b = useImm ? dataT'(imm) : ((srcB == '0) ? '0 : modelRegs[srcB]);
		sa = int'($signed(a));
		sb = int'($signed(b));
		e.psr = modelPsr;
		e.dest = dest;
		e.wrote = (op != opCmp);
		case (op)
			opAdd: begin
				wide = 32'(a) + 32'(b);
				sres = sa + sb;
				e.data = wide[15:0];
				e.psr[psrC] = wide[16];
				// Signed sum out of 16-bit range
				e.psr[psrF] = (sres > 32767) || (sres < -32768);
			end
			opSub: begin
				sres = sa - sb;
				e.data = a - b;
				// Borrow
				e.psr[psrC] = a < b;
				e.psr[psrF] = (sres > 32767) || (sres < -32768);
			end
			opOr:  e.data = a | b;
			opAnd: e.data = a & b;
			opXor: e.data = a ^ b;
			opNot: e.data = ~a;
			opMult: begin
				wide = 32'(a) * 32'(b);
				e.data = wide[15:0];
			end
			default: begin
				e.data = a - b;
				e.psr[psrL] = a < b;
				e.psr[psrZ] = a == b;
				e.psr[psrN] = sa < sb;
			end
		endcase
		if (e.wrote && dest != '0) begin
			modelRegs[dest] = e.data;
		end
		modelPsr = e.psr;
		return e;
	endfunction

	task automatic compareField(input string name, input logic [15:0] got,
		input logic [15:0] want);
		if (got !== want) begin
			$display("Fail %s: got %h, expected %h (result %0d)", name, got, want,
				resultCount);
			errorCount++;
			testErrors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Watch both ports, mid-cycle where everything is settled
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		expectT want;
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				modelRegs[i] = '0;
			end
			modelPsr = '0;
			expected.delete();
		end else begin
			// Results lag inputs by two edges at least
			if (inValid && inReady) begin
				expected.push_back(applyInstr(inOp, inDest, inSrcA, inSrcB, inUseImm, inImm));
			end
			if (resValid && resReady) begin
				if (expected.size() == 0) begin
					$display("Result for r%0d came out with no instruction pending", resDest);
					errorCount++;
					testErrors++;
				end else begin
					want = expected.pop_front();
					compareField("resData", resData, want.data);
					compareField("resDest", 16'(resDest), 16'(want.dest));
					compareField("resWrote", 16'(resWrote), 16'(want.wrote));
					compareField("resPsr", 16'(resPsr), 16'(want.psr));
				end
				resultCount++;
				// One line per finished test
				if (resultCount % perTest == 0 && resultCount / perTest <= 5) begin
					$display("Test %0d (%s): %0d results, %0d errors", resultCount / perTest,
						testNames[resultCount / perTest - 1], perTest, testErrors);
					testErrors = 0;
				end
			end
			pendingCount = expected.size();
		end
	end

endmodule

`default_nettype wire

// ==== verif/aluCoreTb.sv ====
`default_nettype none

module aluCoreTb
	import archPkg::*, isaPkg::*;
();

	localparam int testCount = 5;
	localparam int perTest = 200;
	// Eight cycles per instruction is ample even with stalls
	localparam int cycleLimit = testCount * perTest * 8;

	logic clk;
	logic rst;
	logic inValid;
	logic inReady;
	aluOpE inOp;
	regIdxT inDest;
	regIdxT inSrcA;
	regIdxT inSrcB;
	logic inUseImm;
	immT inImm;
	logic resValid;
	logic resReady;
	dataT resData;
	regIdxT resDest;
	logic resWrote;
	psrT resPsr;

	// Checker results
	int errorCount;
	int resultCount;
	int pendingCount;
	int cycles;

	aluCore u_dut (.*);

	aluCoreChecker resultCheck (.*);

	//////////////////////////////////////////////////////////////////////
	// Clock, timeout, back-pressure
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Done: errors found");
			$finish;
		end
	end

	// resReady low about 30 percent of cycles
	always @(posedge clk) begin
		#2;
		resReady = ($urandom_range(0, 99) >= 30);
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	// Mostly r1 to r4 so hazards come often, r0 now and then
	function automatic regIdxT pickReg();
		int r;
		r = $urandom_range(0, 99);
		if (r < 8) return '0;
		if (r < 80) return regIdxT'($urandom_range(1, 4));
		return regIdxT'($urandom_range(5, 15));
	endfunction

	// Overflow corners mixed into plain random values
	function automatic immT pickImm();
		case ($urandom_range(0, 7))
			0: return 16'h7fff;
			1: return 16'h8000;
			2: return 16'hffff;
			3: return 16'h0001;
			default: return immT'($urandom);
		endcase
	endfunction

	// Payload for one instruction, mix depends on the test
	task automatic driveInstr(input int testNo);
		int pick;
		pick = $urandom_range(0, 99);
		inDest = pickReg();
		inSrcA = pickReg();
		inSrcB = pickReg();
		inUseImm = ($urandom_range(0, 1) == 1);
		inImm = pickImm();
		case (testNo)
			0: inOp = (pick < 60) ? opAdd : aluOpE'($urandom_range(0, 7));
			1: inOp = (pick < 50) ? opAdd : opSub;
			2: inOp = (pick < 60) ? opCmp : opAdd;
			3: inOp = (pick < 25) ? opAdd : aluOpE'($urandom_range(2, 6));
			default: inOp = aluOpE'($urandom_range(0, 7));
		endcase
		// ADD from r0 with an immediate is a register load
		if (inOp == opAdd && testNo != 1 && testNo != 4) begin
			inSrcA = '0;
			inUseImm = 1'b1;
		end
	endtask

	// Hold until inReady, transfer lands on the next rising edge
	task automatic sendInstr(input int testNo);
		driveInstr(testNo);
		inValid = 1'b1;
		@(negedge clk);
		while (!inReady) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		inValid = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hd27c60fe));
		cycles = 0;
		rst = 1'b1;
		inValid = 1'b0;
		inOp = opAdd;
		inDest = '0;
		inSrcA = '0;
		inSrcB = '0;
		inUseImm = 1'b0;
		inImm = '0;
		resReady = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int t = 0; t < testCount; t++) begin
			for (int i = 0; i < perTest; i++) begin
				sendInstr(t);
				// Occasional idle cycle on the input
				if ($urandom_range(0, 9) == 0) begin
					@(posedge clk);
					#1;
				end
			end
		end

		// Drain, then a few spare cycles to catch extra results
		while (resultCount < testCount * perTest) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);

		$display("Summary: %0d results, %0d errors, %0d left over, %0d assertion failures",
			resultCount, errorCount, pendingCount, u_dut.assertInst.failCount);
		if (pendingCount != 0) begin
			$display("Expected results were still waiting at the end of the run");
		end
		if (errorCount == 0 && pendingCount == 0 && u_dut.assertInst.failCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/aluCore_assert.sv ====
`default_nettype none

module aluCoreAssert
	import archPkg::*, isaPkg::*;
(
	input logic   clk,
	input logic   rst,
	input logic   inValid,
	input logic   inReady,
	input aluOpE  inOp,
	input regIdxT inDest,
	input regIdxT inSrcA,
	input regIdxT inSrcB,
	input logic   inUseImm,
	input immT    inImm,
	input logic   resValid,
	input logic   resReady,
	input dataT   resData,
	input regIdxT resDest,
	input logic   resWrote,
	input psrT    resPsr
);

	// Failed assertions so far
	int failCount = 0;

	// Result held while stalled
	assert property (@(posedge clk) disable iff (rst)
		resValid && !resReady |=> resValid && $stable({resData, resDest, resWrote, resPsr}))
		else begin
			failCount++;
			$error("result output dropped or changed under back-pressure");
		end

	// Instruction held until accepted
	assert property (@(posedge clk) disable iff (rst)
		inValid && !inReady |=>
			inValid && $stable({inOp, inDest, inSrcA, inSrcB, inUseImm, inImm}))
		else begin
			failCount++;
			$error("instruction input dropped or changed before acceptance");
		end

	// Output empty right after reset
	assert property (@(posedge clk) rst |=> !resValid)
		else begin
			failCount++;
			$error("resValid high in the cycle after reset");
		end

endmodule

bind aluCore aluCoreAssert assertInst (.*);

`default_nettype wire
